// File: project.f
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/rv_instr_decode.sv
verilog/rv_decode_flow.sv
verilog/rv_decode_stage.sv
test/tb_rv_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# compile the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
	--top-module tb_rv_decode_stage -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "all tests passed" \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }

// File: test/tb_rv_decode_stage.sv
/*
 * directed testbench for the decode stage:
 * instruction encoders, LFSR stimulus, value check,
 * reset, ALU, memory, control transfer, exception and PC flow tests
 */

`include "rv_decode_config.svh"

`default_nettype none

module tb_rv_decode_stage
	import rv_decode_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] opc_reg    = 7'b0110011;
	localparam logic [6:0] opc_imm    = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_system = 7'b1110011;

	logic                clk;
	logic                rst_n;
	logic [`RV_XLEN-1:0] cir_i;
	logic                cir_vld_i;
	logic                cir_err_i;
	logic                x_stall_i;
	logic                jump_now_i;
	logic [`RV_XLEN-1:0] jump_target_i;
	logic                cir_use_o;
	logic [`RV_XLEN-1:0] pc_o;
	d_ctrl_t             ctrl_o;

	logic [15:0] lfsr_state = 16'd25;
	int          errors = 0;

	rv_decode_stage i_rv_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.cir_i         (cir_i),
		.cir_vld_i     (cir_vld_i),
		.cir_err_i     (cir_err_i),
		.x_stall_i     (x_stall_i),
		.jump_now_i    (jump_now_i),
		.jump_target_i (jump_target_i),
		.cir_use_o     (cir_use_o),
		.pc_o          (pc_o),
		.ctrl_o        (ctrl_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] val;
		val = rand_bits(5);
		return val[4:0];
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	// bit 0 of a branch or jump offset is not encoded
	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	task automatic drive(input logic [31:0] word, input logic vld, input logic err,
			input logic stall, input logic jump, input logic [31:0] target);
		@(posedge clk);
		cir_i         <= word;
		cir_vld_i     <= vld;
		cir_err_i     <= err;
		x_stall_i     <= stall;
		jump_now_i    <= jump;
		jump_target_i <= target;
		// outputs are settled by the falling edge
		@(negedge clk);
	endtask

	task automatic present(input logic [31:0] word);
		drive(word, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0);
	endtask

	// ------------------------------
	// checks
	// ------------------------------

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_regs(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [4:0] rd);
		check("ctrl_o.rs1", 32'(ctrl_o.rs1), 32'(rs1));
		check("ctrl_o.rs2", 32'(ctrl_o.rs2), 32'(rs2));
		check("ctrl_o.rd", 32'(ctrl_o.rd), 32'(rd));
	endtask

	task automatic check_alu(input alu_op_e op, input alusrc_b_e srcb);
		check("ctrl_o.aluop", 32'(ctrl_o.aluop), 32'(op));
		check("ctrl_o.alusrc_a", 32'(ctrl_o.alusrc_a), 32'(alusrca_rs1));
		check("ctrl_o.alusrc_b", 32'(ctrl_o.alusrc_b), 32'(srcb));
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_none));
	endtask

	// ------------------------------
	// tests
	// ------------------------------

	task automatic test_reset_starve();
		drive(enc_r(7'h00, 5'd7, 5'd9, 3'b000, 5'd11, opc_reg), 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		check("pc_o", pc_o, `RV_RESET_VECTOR);
		check_regs(5'd0, 5'd0, 5'd0);
		check("ctrl_o.memop", 32'(ctrl_o.memop), 32'(memop_none));
		check("ctrl_o.branchcond", 32'(ctrl_o.branchcond), 32'(bcond_never));
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_none));
		check("cir_use_o", 32'(cir_use_o), 32'd0);
	endtask

	task automatic test_alu_decode();
		logic [31:0] t;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [11:0] imm;
		for (int i = 0; i < 3; i++) begin
			rs1 = rand_reg();
			rs2 = rand_reg();
			rd  = rand_reg();
			t   = rand_bits(20);
			imm = t[11:0];
			present(enc_r(7'h00, rs2, rs1, 3'b000, rd, opc_reg));
			check_alu(aluop_add, alusrcb_rs2);
			check_regs(rs1, rs2, rd);
			present(enc_r(7'h20, rs2, rs1, 3'b000, rd, opc_reg));
			check_alu(aluop_sub, alusrcb_rs2);
			check_regs(rs1, rs2, rd);
			present(enc_i(imm, rs1, 3'b000, rd, opc_imm));
			check_alu(aluop_add, alusrcb_imm);
			check_regs(rs1, 5'd0, rd);
			check("ctrl_o.imm", ctrl_o.imm, {{20{imm[11]}}, imm});
			present(enc_i(imm, rs1, 3'b100, rd, opc_imm));
			check_alu(aluop_xor, alusrcb_imm);
			check("ctrl_o.imm", ctrl_o.imm, {{20{imm[11]}}, imm});
			// SRAI carries 0100000 above the shift amount
			present(enc_i({7'h20, rs2}, rs1, 3'b101, rd, opc_imm));
			check_alu(aluop_sra, alusrcb_imm);
			check_regs(rs1, 5'd0, rd);
			check("ctrl_o.imm", ctrl_o.imm, 32'h400 | 32'(rs2));
			present({t[19:0], rd, opc_lui});
			check("ctrl_o.aluop", 32'(ctrl_o.aluop), 32'(aluop_pass_rs2));
			check("ctrl_o.alusrc_b", 32'(ctrl_o.alusrc_b), 32'(alusrcb_imm));
			check("ctrl_o.imm", ctrl_o.imm, {t[19:0], 12'h000});
			check_regs(5'd0, 5'd0, rd);
		end
	endtask

	task automatic test_mem_decode();
		logic [2:0] ld_f3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
		mem_op_e    ld_op [5] = '{memop_lb, memop_lh, memop_lw, memop_lbu, memop_lhu};
		mem_op_e    st_op [3] = '{memop_sb, memop_sh, memop_sw};
		logic [31:0] t;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		for (int i = 0; i < 5; i++) begin
			rs1 = rand_reg();
			rd  = rand_reg();
			t   = rand_bits(12);
			present(enc_i(t[11:0], rs1, ld_f3[i], rd, opc_load));
			check("ctrl_o.memop", 32'(ctrl_o.memop), 32'(ld_op[i]));
			check("ctrl_o.funct3", 32'(ctrl_o.funct3), 32'(ld_f3[i]));
			check("ctrl_o.addr_offs", ctrl_o.addr_offs, {{20{t[11]}}, t[11:0]});
			check("ctrl_o.addr_is_regoffs", 32'(ctrl_o.addr_is_regoffs), 32'd1);
			check_regs(rs1, 5'd0, rd);
		end
		for (int i = 0; i < 3; i++) begin
			rs1 = rand_reg();
			rs2 = rand_reg();
			t   = rand_bits(12);
			present(enc_s(t[11:0], rs2, rs1, 3'(i)));
			check("ctrl_o.memop", 32'(ctrl_o.memop), 32'(st_op[i]));
			check("ctrl_o.funct3", 32'(ctrl_o.funct3), 32'(i));
			check("ctrl_o.addr_offs", ctrl_o.addr_offs, {{20{t[11]}}, t[11:0]});
			check_regs(rs1, rs2, 5'd0);
		end
	endtask

	task automatic test_ctrl_transfer();
		logic [2:0] br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		alu_op_e    br_op [6] = '{aluop_sub, aluop_sub, aluop_slt, aluop_slt,
			aluop_sltu, aluop_sltu};
		bcond_e     br_cc [6] = '{bcond_zero, bcond_nzero, bcond_nzero, bcond_zero,
			bcond_nzero, bcond_zero};
		logic [31:0] t;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		for (int i = 0; i < 6; i++) begin
			rs1 = rand_reg();
			t   = rand_bits(12);
			present(enc_b({t[11:0], 1'b0}, 5'd3, rs1, br_f3[i]));
			check("ctrl_o.aluop", 32'(ctrl_o.aluop), 32'(br_op[i]));
			check("ctrl_o.branchcond", 32'(ctrl_o.branchcond), 32'(br_cc[i]));
			check("ctrl_o.addr_offs", ctrl_o.addr_offs, {{19{t[11]}}, t[11:0], 1'b0});
			check_regs(rs1, 5'd3, 5'd0);
		end
		rd = rand_reg();
		t  = rand_bits(20);
		present(enc_j({t[19:0], 1'b0}, rd));
		check("ctrl_o.branchcond", 32'(ctrl_o.branchcond), 32'(bcond_always));
		check("ctrl_o.alusrc_a", 32'(ctrl_o.alusrc_a), 32'(alusrca_pc));
		check("ctrl_o.imm", ctrl_o.imm, 32'd4);
		check("ctrl_o.addr_offs", ctrl_o.addr_offs, {{11{t[19]}}, t[19:0], 1'b0});
		rs1 = rand_reg();
		present(enc_i(t[11:0], rs1, 3'b000, rd, opc_jalr));
		check("ctrl_o.branchcond", 32'(ctrl_o.branchcond), 32'(bcond_always));
		check("ctrl_o.alusrc_a", 32'(ctrl_o.alusrc_a), 32'(alusrca_pc));
		check("ctrl_o.imm", ctrl_o.imm, 32'd4);
		check("ctrl_o.addr_offs", ctrl_o.addr_offs, {{20{t[11]}}, t[11:0]});
		check("ctrl_o.addr_is_regoffs", 32'(ctrl_o.addr_is_regoffs), 32'd1);
	endtask

	task automatic test_exceptions();
		logic [31:0] mul_word;
		logic [31:0] add_word;
		mul_word = enc_r(7'h01, 5'd4, 5'd5, 3'b000, 5'd6, opc_reg);
		add_word = enc_r(7'h00, 5'd4, 5'd5, 3'b000, 5'd6, opc_reg);
		present(mul_word);
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_instr_illegal));
		check_regs(5'd0, 5'd0, 5'd0);
		// CSRRW x6, 0x300, x5
		present(enc_i(12'h300, 5'd5, 3'b001, 5'd6, opc_system));
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_instr_illegal));
		check_regs(5'd0, 5'd0, 5'd0);
		drive(add_word, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0);
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_instr_fault));
		check_regs(5'd0, 5'd0, 5'd0);
		drive(mul_word, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0);
		check("ctrl_o.except", 32'(ctrl_o.except), 32'(except_instr_fault));
	endtask

	task automatic test_pc_flow();
		logic [31:0] word;
		logic [31:0] pc_start;
		logic [31:0] target;
		logic [31:0] t;
		word = enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, opc_reg);
		drive(word, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		pc_start = pc_o;
		present(word);
		check("cir_use_o", 32'(cir_use_o), 32'd1);
		check("pc_o", pc_o, pc_start);
		present(word);
		check("pc_o", pc_o, pc_start + 32'd4);
		drive(word, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		check("pc_o", pc_o, pc_start + 32'd8);
		// back-pressure from execute
		drive(word, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
		check("cir_use_o", 32'(cir_use_o), 32'd0);
		drive(word, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
		check("pc_o", pc_o, pc_start + 32'd8);
		t      = rand_bits(30);
		target = {t[29:0], 2'b00};
		drive(word, 1'b1, 1'b0, 1'b1, 1'b1, target);
		check("pc_o", pc_o, pc_start + 32'd8);
		drive(word, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
		check("pc_o", pc_o, target);
		present(word);
		check("cir_use_o", 32'(cir_use_o), 32'd1);
		drive(word, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
		check("pc_o", pc_o, target + 32'd4);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		rst_n         <= 1'b0;
		cir_i         <= '0;
		cir_vld_i     <= 1'b0;
		cir_err_i     <= 1'b0;
		x_stall_i     <= 1'b0;
		jump_now_i    <= 1'b0;
		jump_target_i <= '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_starve();
		test_alu_decode();
		test_mem_decode();
		test_ctrl_transfer();
		test_exceptions();
		test_pc_flow();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/rv_decode_stage.sv
/*
 * decode stage top level:
 * instruction decoder feeding the flow control and PC block
 */

`include "rv_decode_config.svh"

`default_nettype none

module rv_decode_stage
	import rv_decode_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,

	input  logic [`RV_XLEN-1:0] cir_i,
	input  logic                cir_vld_i,
	input  logic                cir_err_i,
	input  logic                x_stall_i,
	input  logic                jump_now_i,
	input  logic [`RV_XLEN-1:0] jump_target_i,

	output logic                cir_use_o,
	output logic [`RV_XLEN-1:0] pc_o,
	output d_ctrl_t             ctrl_o
);

	// decoder output before any gating
	d_ctrl_t raw_ctrl;
	logic    illegal;

	rv_instr_decode i_rv_instr_decode (
		.cir_i      (cir_i),
		.raw_ctrl_o (raw_ctrl),
		.illegal_o  (illegal)
	);

	rv_decode_flow i_rv_decode_flow (
		.clk           (clk),
		.rst_n         (rst_n),
		.raw_ctrl_i    (raw_ctrl),
		.illegal_i     (illegal),
		.cir_vld_i     (cir_vld_i),
		.cir_err_i     (cir_err_i),
		.x_stall_i     (x_stall_i),
		.jump_now_i    (jump_now_i),
		.jump_target_i (jump_target_i),
		.cir_use_o     (cir_use_o),
		.pc_o          (pc_o),
		.ctrl_o        (ctrl_o)
	);

endmodule

`default_nettype wire

// File: verilog/rv_decode_flow.sv
/*
 * decode stage flow control:
 * consume handshake with the fetch buffer, gating of the control
 * bundle on starvation, fetch fault or illegal instruction,
 * and the decode PC register
 */

`include "rv_decode_config.svh"

`default_nettype none

module rv_decode_flow
	import rv_decode_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,

	input  d_ctrl_t             raw_ctrl_i,
	input  logic                illegal_i,

	input  logic                cir_vld_i,
	input  logic                cir_err_i,
	input  logic                x_stall_i,
	input  logic                jump_now_i,
	input  logic [`RV_XLEN-1:0] jump_target_i,

	output logic                cir_use_o,
	output logic [`RV_XLEN-1:0] pc_o,
	output d_ctrl_t             ctrl_o
);

	localparam logic [`RV_XLEN-1:0] pc_step = `RV_XLEN'(4);

	logic                starved;
	logic                bus_fault;
	logic [`RV_XLEN-1:0] pc_q;

	// ------------------------------
	// handshake
	// ------------------------------

	assign starved = !cir_vld_i;

	// a fault only counts for a word that is actually present
	assign bus_fault = cir_vld_i && cir_err_i;

	assign cir_use_o = cir_vld_i && !x_stall_i;

	// ------------------------------
	// control gating
	// ------------------------------

	always_comb begin
		ctrl_o = raw_ctrl_i;
		if (illegal_i || starved || bus_fault) begin
			// nothing may reach the register file, memory or branch unit
			ctrl_o.rs1             = '0;
			ctrl_o.rs2             = '0;
			ctrl_o.rd              = '0;
			ctrl_o.memop           = memop_none;
			ctrl_o.branchcond      = bcond_never;
			ctrl_o.except          = except_none;
			ctrl_o.addr_is_regoffs = 1'b1;

			// a failed fetch makes the word meaningless, so it wins over illegal
			if (bus_fault) begin
				ctrl_o.except = except_instr_fault;
			end else if (illegal_i && !starved) begin
				ctrl_o.except = except_instr_illegal;
			end
		end
	end

	// ------------------------------
	// PC register
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `RV_RESET_VECTOR;
		end else if (jump_now_i) begin
			// redirect applies even while execute stalls
			pc_q <= jump_target_i;
		end else if (cir_use_o) begin
			pc_q <= pc_q + pc_step;
		end
	end

	assign pc_o = pc_q;

	// every instruction is 32 bits, so the PC never leaves word alignment
	pc_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc_o[1:0] == 2'b00
	);

	// execute back-pressure keeps the decode PC unless the frontend redirects
	pc_held_while_stalled: assert property (
		@(posedge clk) disable iff (!rst_n)
		x_stall_i && !jump_now_i |=> $stable(pc_o)
	);

endmodule

`default_nettype wire

// File: verilog/rv_instr_decode.sv
/*
 * combinational RV32I instruction decoder:
 * I, S, B, U and J immediates, per-opcode execute controls,
 * address offset selection and the illegal instruction flag
 */

`include "rv_decode_config.svh"

`default_nettype none

module rv_instr_decode
	import rv_decode_pkg::*;
(
	input  logic [`RV_XLEN-1:0] cir_i,
	output d_ctrl_t             raw_ctrl_o,
	output logic                illegal_o
);

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_fence  = 7'b0001111;

	localparam logic [`RV_REGADDR_W-1:0] x0 = '0;

	// link address is pc plus one instruction
	localparam logic [`RV_XLEN-1:0] link_offs = `RV_XLEN'(4);

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;

	assign opcode = cir_i[6:0];
	assign funct3 = cir_i[14:12];
	assign funct7 = cir_i[31:25];

	// ------------------------------
	// immediate formats
	// ------------------------------

	assign imm_i = {{21{cir_i[31]}}, cir_i[30:20]};
	assign imm_s = {{21{cir_i[31]}}, cir_i[30:25], cir_i[11:7]};
	assign imm_b = {{20{cir_i[31]}}, cir_i[7], cir_i[30:25], cir_i[11:8], 1'b0};
	assign imm_u = {cir_i[31:12], 12'h000};
	assign imm_j = {{12{cir_i[31]}}, cir_i[19:12], cir_i[20], cir_i[30:21], 1'b0};

	// ------------------------------
	// execute controls
	// ------------------------------

	always_comb begin
		raw_ctrl_o.rs1             = cir_i[19:15];
		raw_ctrl_o.rs2             = cir_i[24:20];
		raw_ctrl_o.rd              = cir_i[11:7];
		raw_ctrl_o.imm             = imm_i;
		raw_ctrl_o.alusrc_a        = alusrca_rs1;
		raw_ctrl_o.alusrc_b        = alusrcb_rs2;
		raw_ctrl_o.aluop           = aluop_add;
		raw_ctrl_o.funct3          = funct3;
		raw_ctrl_o.memop           = memop_none;
		raw_ctrl_o.branchcond      = bcond_never;
		raw_ctrl_o.addr_is_regoffs = 1'b0;
		raw_ctrl_o.except          = except_none;
		illegal_o                  = 1'b0;

		case (opcode)
			op_lui: begin
				raw_ctrl_o.aluop    = aluop_pass_rs2;
				raw_ctrl_o.imm      = imm_u;
				raw_ctrl_o.alusrc_b = alusrcb_imm;
				raw_ctrl_o.rs1      = x0;
				raw_ctrl_o.rs2      = x0;
			end
			op_auipc: begin
				raw_ctrl_o.imm      = imm_u;
				raw_ctrl_o.alusrc_a = alusrca_pc;
				raw_ctrl_o.alusrc_b = alusrcb_imm;
				raw_ctrl_o.rs1      = x0;
				raw_ctrl_o.rs2      = x0;
			end
			op_jal: begin
				raw_ctrl_o.branchcond = bcond_always;
				raw_ctrl_o.alusrc_a   = alusrca_pc;
				raw_ctrl_o.alusrc_b   = alusrcb_imm;
				raw_ctrl_o.imm        = link_offs;
				raw_ctrl_o.rs1        = x0;
				raw_ctrl_o.rs2        = x0;
			end
			op_jalr: begin
				raw_ctrl_o.branchcond      = bcond_always;
				raw_ctrl_o.addr_is_regoffs = 1'b1;
				raw_ctrl_o.alusrc_a        = alusrca_pc;
				raw_ctrl_o.alusrc_b        = alusrcb_imm;
				raw_ctrl_o.imm             = link_offs;
				raw_ctrl_o.rs2             = x0;
				illegal_o                  = funct3 != 3'b000;
			end
			op_branch: begin
				// compare result feeds the zero test in execute
				raw_ctrl_o.rd = x0;
				case (funct3)
					3'b000: begin
						raw_ctrl_o.aluop      = aluop_sub;
						raw_ctrl_o.branchcond = bcond_zero;
					end
					3'b001: begin
						raw_ctrl_o.aluop      = aluop_sub;
						raw_ctrl_o.branchcond = bcond_nzero;
					end
					3'b100: begin
						raw_ctrl_o.aluop      = aluop_slt;
						raw_ctrl_o.branchcond = bcond_nzero;
					end
					3'b101: begin
						raw_ctrl_o.aluop      = aluop_slt;
						raw_ctrl_o.branchcond = bcond_zero;
					end
					3'b110: begin
						raw_ctrl_o.aluop      = aluop_sltu;
						raw_ctrl_o.branchcond = bcond_nzero;
					end
					3'b111: begin
						raw_ctrl_o.aluop      = aluop_sltu;
						raw_ctrl_o.branchcond = bcond_zero;
					end
					default: illegal_o = 1'b1;
				endcase
			end
			op_load: begin
				raw_ctrl_o.addr_is_regoffs = 1'b1;
				raw_ctrl_o.rs2             = x0;
				case (funct3)
					3'b000:  raw_ctrl_o.memop = memop_lb;
					3'b001:  raw_ctrl_o.memop = memop_lh;
					3'b010:  raw_ctrl_o.memop = memop_lw;
					3'b100:  raw_ctrl_o.memop = memop_lbu;
					3'b101:  raw_ctrl_o.memop = memop_lhu;
					default: illegal_o = 1'b1;
				endcase
			end
			op_store: begin
				// store data goes through the ALU on the rs2 path
				raw_ctrl_o.addr_is_regoffs = 1'b1;
				raw_ctrl_o.aluop           = aluop_pass_rs2;
				raw_ctrl_o.rd              = x0;
				case (funct3)
					3'b000:  raw_ctrl_o.memop = memop_sb;
					3'b001:  raw_ctrl_o.memop = memop_sh;
					3'b010:  raw_ctrl_o.memop = memop_sw;
					default: illegal_o = 1'b1;
				endcase
			end
			op_imm: begin
				raw_ctrl_o.alusrc_b = alusrcb_imm;
				raw_ctrl_o.rs2      = x0;
				case (funct3)
					3'b000: raw_ctrl_o.aluop = aluop_add;
					3'b010: raw_ctrl_o.aluop = aluop_slt;
					3'b011: raw_ctrl_o.aluop = aluop_sltu;
					3'b100: raw_ctrl_o.aluop = aluop_xor;
					3'b110: raw_ctrl_o.aluop = aluop_or;
					3'b111: raw_ctrl_o.aluop = aluop_and;
					3'b001: begin
						raw_ctrl_o.aluop = aluop_sll;
						illegal_o        = funct7 != 7'b0000000;
					end
					default: begin
						// shift right, funct7 picks logical or arithmetic
						raw_ctrl_o.aluop = funct7[5] ? aluop_sra : aluop_srl;
						illegal_o        = {funct7[6], funct7[4:0]} != 6'b000000;
					end
				endcase
			end
			op_reg: begin
				// M extension (funct7 0000001) falls through to illegal
				case ({funct7, funct3})
					10'b0000000_000: raw_ctrl_o.aluop = aluop_add;
					10'b0100000_000: raw_ctrl_o.aluop = aluop_sub;
					10'b0000000_001: raw_ctrl_o.aluop = aluop_sll;
					10'b0000000_010: raw_ctrl_o.aluop = aluop_slt;
					10'b0000000_011: raw_ctrl_o.aluop = aluop_sltu;
					10'b0000000_100: raw_ctrl_o.aluop = aluop_xor;
					10'b0000000_101: raw_ctrl_o.aluop = aluop_srl;
					10'b0100000_101: raw_ctrl_o.aluop = aluop_sra;
					10'b0000000_110: raw_ctrl_o.aluop = aluop_or;
					10'b0000000_111: raw_ctrl_o.aluop = aluop_and;
					default:         illegal_o = 1'b1;
				endcase
			end
			op_fence: begin
				// executes as a no-op, rs1 and rd are zero in the encoding
				raw_ctrl_o.rs2 = x0;
				illegal_o      = funct3 != 3'b000;
			end
			default: illegal_o = 1'b1;
		endcase

		// only full-width encodings exist here
		if (cir_i[1:0] != 2'b11) begin
			illegal_o = 1'b1;
		end
	end

	// ------------------------------
	// address offset
	// ------------------------------

	always_comb begin
		case (opcode)
			op_jal:    raw_ctrl_o.addr_offs = imm_j;
			op_branch: raw_ctrl_o.addr_offs = imm_b;
			op_store:  raw_ctrl_o.addr_offs = imm_s;
			op_jalr:   raw_ctrl_o.addr_offs = imm_i;
			op_load:   raw_ctrl_o.addr_offs = imm_i;
			default:   raw_ctrl_o.addr_offs = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/rv_decode_pkg.sv
/*
 * shared types of the decode stage:
 * enumerations for ALU operation, operand sources, memory operation,
 * branch condition and exception code, and the packed control bundle
 */

`include "rv_decode_config.svh"

`default_nettype none

package rv_decode_pkg;

	// ------------------------------
	// ALU controls
	// ------------------------------

	typedef enum logic [3:0] {
		aluop_add      = 4'h0,
		aluop_sub      = 4'h1,
		aluop_slt      = 4'h2,
		aluop_sltu     = 4'h3,
		aluop_xor      = 4'h4,
		aluop_or       = 4'h5,
		aluop_and      = 4'h6,
		aluop_sll      = 4'h7,
		aluop_srl      = 4'h8,
		aluop_sra      = 4'h9,
		// result is operand B unchanged, used by LUI and stores
		aluop_pass_rs2 = 4'ha
	} alu_op_e;

	typedef enum logic {
		alusrca_rs1 = 1'b0,
		alusrca_pc  = 1'b1
	} alusrc_a_e;

	typedef enum logic {
		alusrcb_rs2 = 1'b0,
		alusrcb_imm = 1'b1
	} alusrc_b_e;

	// ------------------------------
	// memory, branch and exception
	// ------------------------------

	typedef enum logic [3:0] {
		memop_none = 4'h0,
		memop_lb   = 4'h1,
		memop_lh   = 4'h2,
		memop_lw   = 4'h3,
		memop_lbu  = 4'h4,
		memop_lhu  = 4'h5,
		memop_sb   = 4'h6,
		memop_sh   = 4'h7,
		memop_sw   = 4'h8
	} mem_op_e;

	// zero and nzero test the ALU result of the compare
	typedef enum logic [1:0] {
		bcond_never  = 2'h0,
		bcond_always = 2'h1,
		bcond_zero   = 2'h2,
		bcond_nzero  = 2'h3
	} bcond_e;

	typedef enum logic [1:0] {
		except_none          = 2'h0,
		except_instr_illegal = 2'h1,
		except_instr_fault   = 2'h2
	} except_e;

	// everything execute needs to run one instruction
	typedef struct packed {
		logic [`RV_REGADDR_W-1:0] rs1;
		logic [`RV_REGADDR_W-1:0] rs2;
		logic [`RV_REGADDR_W-1:0] rd;
		logic [`RV_XLEN-1:0]      imm;
		logic [`RV_XLEN-1:0]      addr_offs;
		alusrc_a_e                alusrc_a;
		alusrc_b_e                alusrc_b;
		alu_op_e                  aluop;
		logic [2:0]               funct3;
		mem_op_e                  memop;
		bcond_e                   branchcond;
		// address is rs1 plus offset, otherwise pc plus offset
		logic                     addr_is_regoffs;
		except_e                  except;
	} d_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/rv_decode_config.svh
/*
 * build-time constants for the decode stage:
 * data and address width, register index width, reset vector
 */

`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

`default_nettype none

// data and address width of the core
`define RV_XLEN 32

// five bits address the 32 integer registers
`define RV_REGADDR_W 5

// decode PC value after reset
`define RV_RESET_VECTOR 32'h0000_0040

`default_nettype wire

`endif
